// ==== design/cpu_pkg.sv ====
package cpu_pkg;

    // Datapath and register index widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // Stage stall vector, one bit per stage plus the flush bit
    localparam int stall_w     = 6;
    localparam int stall_fetch = 0;
    localparam int stall_id    = 1;
    localparam int stall_ex    = 2;
    localparam int stall_mem   = 3;
    localparam int stall_wb    = 4;
    localparam int stall_flush = 5;

    // ALU operation
    typedef enum logic [3:0] {
        op_nop  = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_and  = 4'd3,
        op_or   = 4'd4,
        op_xor  = 4'd5,
        op_sll  = 4'd6,
        op_srl  = 4'd7,
        op_sra  = 4'd8,
        op_slt  = 4'd9,
        op_sltu = 4'd10
    } alu_op_e;

    // Result class picked at the end of execute
    typedef enum logic [1:0] {
        sel_nop   = 2'd0,
        sel_logic = 2'd1,
        sel_shift = 2'd2,
        sel_link  = 2'd3
    } alu_sel_e;

    // Bubble and reset values
    localparam logic [reg_addr_w-1:0] nop_reg_addr = '0;
    localparam logic [xlen-1:0]       zero_word    = '0;

endpackage

// ==== design/inst_decode.sv ====
`timescale 1ns/1ps

module inst_decode (
    input  logic [cpu_pkg::xlen-1:0]       inst,
    input  logic [cpu_pkg::xlen-1:0]       inst_pc,
    input  logic                           inst_valid,
    input  logic [cpu_pkg::xlen-1:0]       rdata1,
    input  logic [cpu_pkg::xlen-1:0]       rdata2,
    input  logic [cpu_pkg::reg_addr_w-1:0] ex_wd,
    input  logic                           ex_wreg,
    output logic [cpu_pkg::reg_addr_w-1:0] raddr1,
    output logic [cpu_pkg::reg_addr_w-1:0] raddr2,
    output cpu_pkg::alu_op_e               aluop,
    output cpu_pkg::alu_sel_e              alusel,
    output logic [cpu_pkg::xlen-1:0]       reg1,
    output logic [cpu_pkg::xlen-1:0]       reg2,
    output logic [cpu_pkg::xlen-1:0]       imm,
    output logic [cpu_pkg::reg_addr_w-1:0] shamt,
    output logic [cpu_pkg::reg_addr_w-1:0] wd,
    output logic                           wreg,
    output logic [cpu_pkg::xlen-1:0]       pc,
    output logic [cpu_pkg::xlen-1:0]       link_addr,
    output logic                           stall_req
);
    import cpu_pkg::*;

    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] f7_base    = 7'b0000000;
    localparam logic [6:0] f7_alt     = 7'b0100000;

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       imm_i;
    logic [xlen-1:0]       imm_u;
    logic [xlen-1:0]       imm_j;
    logic                  use_rs1;
    logic                  use_rs2;
    logic                  decoded;
    logic                  r_funct_ok;

    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    // Only ADD/SUB and SRL/SRA have an alternate funct7
    assign r_funct_ok = (funct7 == f7_base) ||
                        ((funct7 == f7_alt) && (funct3 == 3'b000 || funct3 == 3'b101));

    assign raddr1 = rs1;
    assign raddr2 = rs2;

    always_comb begin
        aluop   = op_nop;
        alusel  = sel_nop;
        imm     = zero_word;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        if (inst_valid) begin
            case (opcode)
                opc_op: begin
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                    if (r_funct_ok) begin
                        case (funct3)
                            3'b000: aluop = (funct7 == f7_alt) ? op_sub : op_add;
                            3'b001: aluop = op_sll;
                            3'b010: aluop = op_slt;
                            3'b011: aluop = op_sltu;
                            3'b100: aluop = op_xor;
                            3'b101: aluop = (funct7 == f7_alt) ? op_sra : op_srl;
                            3'b110: aluop = op_or;
                            default: aluop = op_and;
                        endcase
                    end
                end
                opc_op_imm: begin
                    use_rs1 = 1'b1;
                    imm     = imm_i;
                    case (funct3)
                        3'b000: aluop = op_add;
                        3'b010: aluop = op_slt;
                        3'b011: aluop = op_sltu;
                        3'b100: aluop = op_xor;
                        3'b110: aluop = op_or;
                        3'b111: aluop = op_and;
                        3'b001: aluop = (funct7 == f7_base) ? op_sll : op_nop;
                        default: begin
                            if (funct7 == f7_base) begin
                                aluop = op_srl;
                            end else if (funct7 == f7_alt) begin
                                aluop = op_sra;
                            end
                        end
                    endcase
                end
                opc_lui: begin
                    aluop = op_add;
                    imm   = imm_u;
                end
                opc_jal: begin
                    // Target is resolved by fetch, only the link is written here
                    aluop  = op_add;
                    alusel = sel_link;
                    imm    = imm_j;
                end
                default: aluop = op_nop;
            endcase
        end

        decoded = (aluop != op_nop);
        if (!decoded) begin
            use_rs1 = 1'b0;
            use_rs2 = 1'b0;
            imm     = zero_word;
        end else if (alusel != sel_link) begin
            alusel = (aluop == op_sll || aluop == op_srl || aluop == op_sra) ? sel_shift
                                                                              : sel_logic;
        end
    end

    assign reg1      = use_rs1 ? rdata1 : zero_word;
    assign reg2      = use_rs2 ? rdata2 : imm;
    // I-type shifts take the immediate field, which sits in imm[4:0]
    assign shamt     = use_rs2 ? rdata2[reg_addr_w-1:0] : imm[reg_addr_w-1:0];
    assign wd        = decoded ? rd : nop_reg_addr;
    assign wreg      = decoded && (rd != nop_reg_addr);
    assign pc        = decoded ? inst_pc : zero_word;
    assign link_addr = decoded ? inst_pc + 32'd4 : zero_word;

    // No forwarding, so any read of the execute destination waits one cycle
    assign stall_req = ex_wreg &&
                       ((use_rs1 && rs1 != nop_reg_addr && rs1 == ex_wd) ||
                        (use_rs2 && rs2 != nop_reg_addr && rs2 == ex_wd));

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [cpu_pkg::reg_addr_w-1:0] raddr1,
    input  logic [cpu_pkg::reg_addr_w-1:0] raddr2,
    output logic [cpu_pkg::xlen-1:0]       rdata1,
    output logic [cpu_pkg::xlen-1:0]       rdata2,
    input  logic                           we,
    input  logic [cpu_pkg::reg_addr_w-1:0] waddr,
    input  logic [cpu_pkg::xlen-1:0]       wdata
);
    import cpu_pkg::*;

    // x1..x31, x0 is not stored
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= zero_word;
            end
        end else if (we && waddr != nop_reg_addr) begin
            regs[waddr] <= wdata;
        end
    end

    // Write data passes straight through to a read of the same register
    always_comb begin
        if (raddr1 == nop_reg_addr) begin
            rdata1 = zero_word;
        end else if (we && raddr1 == waddr) begin
            rdata1 = wdata;
        end else begin
            rdata1 = regs[raddr1];
        end

        if (raddr2 == nop_reg_addr) begin
            rdata2 = zero_word;
        end else if (we && raddr2 == waddr) begin
            rdata2 = wdata;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

// ==== design/stall_ctrl.sv ====
`timescale 1ns/1ps

module stall_ctrl (
    input  logic                        hold,
    input  logic                        stall_req,
    input  logic                        flush,
    output logic [cpu_pkg::stall_w-1:0] stall
);
    import cpu_pkg::*;

    logic front_stop;

    // Hazard only stops fetch and decode, execute keeps moving and takes a bubble
    assign front_stop = hold | stall_req;

    assign stall[stall_fetch] = front_stop;
    assign stall[stall_id]    = front_stop;

    // Hold freezes execute and everything after it as well
    assign stall[stall_ex]  = hold;
    assign stall[stall_mem] = hold;
    assign stall[stall_wb]  = hold;

    assign stall[stall_flush] = flush;

endmodule

// ==== design/id_ex.sv ====
`timescale 1ns/1ps

module id_ex (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [cpu_pkg::stall_w-1:0]    stall,
    input  cpu_pkg::alu_op_e               id_aluop,
    input  cpu_pkg::alu_sel_e              id_alusel,
    input  logic [cpu_pkg::xlen-1:0]       id_reg1,
    input  logic [cpu_pkg::xlen-1:0]       id_reg2,
    input  logic [cpu_pkg::xlen-1:0]       id_imm,
    input  logic [cpu_pkg::reg_addr_w-1:0] id_shamt,
    input  logic [cpu_pkg::reg_addr_w-1:0] id_wd,
    input  logic                           id_wreg,
    input  logic [cpu_pkg::xlen-1:0]       id_pc,
    input  logic [cpu_pkg::xlen-1:0]       id_link_addr,
    output cpu_pkg::alu_op_e               ex_aluop,
    output cpu_pkg::alu_sel_e              ex_alusel,
    output logic [cpu_pkg::xlen-1:0]       ex_reg1,
    output logic [cpu_pkg::xlen-1:0]       ex_reg2,
    output logic [cpu_pkg::xlen-1:0]       ex_imm,
    output logic [cpu_pkg::reg_addr_w-1:0] ex_shamt,
    output logic [cpu_pkg::reg_addr_w-1:0] ex_wd,
    output logic                           ex_wreg,
    output logic [cpu_pkg::xlen-1:0]       ex_pc,
    output logic [cpu_pkg::xlen-1:0]       ex_link_addr
);
    import cpu_pkg::*;

    logic load_bubble;
    logic hold_ex;

    // Reset, flush, then decode stopped while execute moves on
    assign load_bubble = !rst_n || stall[stall_flush] ||
                         (stall[stall_id] && !stall[stall_ex]);
    assign hold_ex     = stall[stall_ex];

    always_ff @(posedge clk) begin
        if (load_bubble) begin
            ex_aluop     <= op_nop;
            ex_alusel    <= sel_nop;
            ex_reg1      <= zero_word;
            ex_reg2      <= zero_word;
            ex_imm       <= zero_word;
            ex_shamt     <= '0;
            ex_wd        <= nop_reg_addr;
            ex_wreg      <= 1'b0;
            ex_pc        <= zero_word;
            ex_link_addr <= zero_word;
        end else if (!hold_ex) begin
            ex_aluop     <= id_aluop;
            ex_alusel    <= id_alusel;
            ex_reg1      <= id_reg1;
            ex_reg2      <= id_reg2;
            ex_imm       <= id_imm;
            ex_shamt     <= id_shamt;
            ex_wd        <= id_wd;
            ex_wreg      <= id_wreg;
            ex_pc        <= id_pc;
            ex_link_addr <= id_link_addr;
        end
    end

endmodule

// ==== design/alu_execute.sv ====
`timescale 1ns/1ps

module alu_execute (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [cpu_pkg::stall_w-1:0]    stall,
    input  cpu_pkg::alu_op_e               aluop,
    input  cpu_pkg::alu_sel_e              alusel,
    input  logic [cpu_pkg::xlen-1:0]       reg1,
    input  logic [cpu_pkg::xlen-1:0]       reg2,
    input  logic [cpu_pkg::reg_addr_w-1:0] shamt,
    input  logic [cpu_pkg::reg_addr_w-1:0] wd,
    input  logic                           wreg,
    input  logic [cpu_pkg::xlen-1:0]       link_addr,
    output logic                           wb_we,
    output logic [cpu_pkg::reg_addr_w-1:0] wb_addr,
    output logic [cpu_pkg::xlen-1:0]       wb_data
);
    import cpu_pkg::*;

    logic [xlen-1:0] arith_res;
    logic [xlen-1:0] shift_res;
    logic [xlen-1:0] result;
    logic            hold_wb;

    always_comb begin
        case (aluop)
            op_add:  arith_res = reg1 + reg2;
            op_sub:  arith_res = reg1 - reg2;
            op_and:  arith_res = reg1 & reg2;
            op_or:   arith_res = reg1 | reg2;
            op_xor:  arith_res = reg1 ^ reg2;
            op_slt:  arith_res = {{(xlen-1){1'b0}}, $signed(reg1) < $signed(reg2)};
            op_sltu: arith_res = {{(xlen-1){1'b0}}, reg1 < reg2};
            default: arith_res = zero_word;
        endcase
    end

    always_comb begin
        case (aluop)
            op_sll:  shift_res = reg1 << shamt;
            op_srl:  shift_res = reg1 >> shamt;
            op_sra:  shift_res = $unsigned($signed(reg1) >>> shamt);
            default: shift_res = zero_word;
        endcase
    end

    always_comb begin
        case (alusel)
            sel_logic: result = arith_res;
            sel_shift: result = shift_res;
            sel_link:  result = link_addr;
            default:   result = zero_word;
        endcase
    end

    // No memory stage, so its stall bit also freezes this register
    assign hold_wb = stall[stall_mem] | stall[stall_wb];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_we <= 1'b0;
        end else if (!hold_wb) begin
            wb_we <= wreg;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_wb) begin
            wb_addr <= wd;
            wb_data <= result;
        end
    end

endmodule

// ==== design/decode_exec_top.sv ====
`timescale 1ns/1ps

module decode_exec_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [cpu_pkg::xlen-1:0]       inst,
    input  logic [cpu_pkg::xlen-1:0]       inst_pc,
    input  logic                           inst_valid,
    input  logic                           hold,
    input  logic                           flush,
    output logic                           id_stall,
    output logic                           wb_we,
    output logic [cpu_pkg::reg_addr_w-1:0] wb_addr,
    output logic [cpu_pkg::xlen-1:0]       wb_data
);
    import cpu_pkg::*;

    // Decode side
    logic [reg_addr_w-1:0] raddr1;
    logic [reg_addr_w-1:0] raddr2;
    logic [xlen-1:0]       rdata1;
    logic [xlen-1:0]       rdata2;
    alu_op_e               id_aluop;
    alu_sel_e              id_alusel;
    logic [xlen-1:0]       id_reg1;
    logic [xlen-1:0]       id_reg2;
    logic [xlen-1:0]       id_imm;
    logic [reg_addr_w-1:0] id_shamt;
    logic [reg_addr_w-1:0] id_wd;
    logic                  id_wreg;
    logic [xlen-1:0]       id_pc;
    logic [xlen-1:0]       id_link_addr;
    logic                  stall_req;
    logic [stall_w-1:0]    stall;

    // Execute side
    alu_op_e               ex_aluop;
    alu_sel_e              ex_alusel;
    logic [xlen-1:0]       ex_reg1;
    logic [xlen-1:0]       ex_reg2;
    logic [xlen-1:0]       ex_imm;
    logic [reg_addr_w-1:0] ex_shamt;
    logic [reg_addr_w-1:0] ex_wd;
    logic                  ex_wreg;
    logic [xlen-1:0]       ex_pc;
    logic [xlen-1:0]       ex_link_addr;

    assign id_stall = stall[stall_id];

    inst_decode u_decode (
        .inst       (inst),        .inst_pc   (inst_pc),      .inst_valid (inst_valid),
        .rdata1     (rdata1),      .rdata2    (rdata2),       .ex_wd      (ex_wd),
        .ex_wreg    (ex_wreg),     .raddr1    (raddr1),       .raddr2     (raddr2),
        .aluop      (id_aluop),    .alusel    (id_alusel),    .reg1       (id_reg1),
        .reg2       (id_reg2),     .imm       (id_imm),       .shamt      (id_shamt),
        .wd         (id_wd),       .wreg      (id_wreg),      .pc         (id_pc),
        .link_addr  (id_link_addr), .stall_req (stall_req)
    );

    reg_file u_regs (
        .clk    (clk),    .rst_n  (rst_n),
        .raddr1 (raddr1), .raddr2 (raddr2), .rdata1 (rdata1), .rdata2 (rdata2),
        .we     (wb_we),  .waddr  (wb_addr), .wdata (wb_data)
    );

    stall_ctrl u_stall (
        .hold (hold), .stall_req (stall_req), .flush (flush), .stall (stall)
    );

    id_ex u_id_ex (
        .clk          (clk),          .rst_n        (rst_n),        .stall     (stall),
        .id_aluop     (id_aluop),     .id_alusel    (id_alusel),    .id_reg1   (id_reg1),
        .id_reg2      (id_reg2),      .id_imm       (id_imm),       .id_shamt  (id_shamt),
        .id_wd        (id_wd),        .id_wreg      (id_wreg),      .id_pc     (id_pc),
        .id_link_addr (id_link_addr), .ex_aluop     (ex_aluop),     .ex_alusel (ex_alusel),
        .ex_reg1      (ex_reg1),      .ex_reg2      (ex_reg2),      .ex_imm    (ex_imm),
        .ex_shamt     (ex_shamt),     .ex_wd        (ex_wd),        .ex_wreg   (ex_wreg),
        .ex_pc        (ex_pc),        .ex_link_addr (ex_link_addr)
    );

    alu_execute u_exec (
        .clk    (clk),       .rst_n  (rst_n),     .stall     (stall),
        .aluop  (ex_aluop),  .alusel (ex_alusel), .reg1      (ex_reg1),
        .reg2   (ex_reg2),   .shamt  (ex_shamt),  .wd        (ex_wd),
        .wreg   (ex_wreg),   .link_addr (ex_link_addr),
        .wb_we  (wb_we),     .wb_addr (wb_addr),  .wb_data   (wb_data)
    );

endmodule

// ==== verification/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;
    import cpu_pkg::*;

    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] f7_alt     = 7'b0100000;
    // Timeout budget sized from the instruction, hold and stall counts of the tests
    localparam int n_insts     = 51;
    localparam int n_hold_max  = 6;
    localparam int n_stalls    = 3;
    localparam int cycle_limit = 2 * n_insts + n_hold_max + n_stalls + 200;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic [xlen-1:0]       inst;
    logic [xlen-1:0]       inst_pc;
    logic                  inst_valid;
    logic                  hold;
    logic                  flush;
    logic                  id_stall;
    logic                  wb_we;
    logic [reg_addr_w-1:0] wb_addr;
    logic [xlen-1:0]       wb_data;

    logic [xlen-1:0]       model [0:31];
    logic [reg_addr_w-1:0] q_addr [$];
    logic [xlen-1:0]       q_data [$];
    int                    q_edge [$];
    int                    q_hold [$];
    logic [31:0]           seed = 32'h83da;
    logic [xlen-1:0]       pc_q = 32'h0000_1000;
    logic                  hold_q = 1'b0;
    logic                  op_pending = 1'b0;
    alu_op_e               exp_op;
    int                    edge_no = 0;
    int                    hold_edges = 0;
    int                    cycle_cnt = 0;
    int                    errors = 0;
    int                    results = 0;

    decode_exec_top dut (
        .clk        (clk),        .rst_n   (rst_n),   .inst     (inst),
        .inst_pc    (inst_pc),    .inst_valid (inst_valid), .hold (hold),
        .flush      (flush),      .id_stall (id_stall), .wb_we  (wb_we),
        .wb_addr    (wb_addr),    .wb_data (wb_data)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] rand_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // RV32I result by funct3 where b is rs2 or the sign-extended immediate
    function automatic logic [xlen-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                                input logic [xlen-1:0] a,
                                                input logic [xlen-1:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic alu_op_e op_of(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0: if (alt) return op_sub; else return op_add;
            3'd1: return op_sll;
            3'd2: return op_slt;
            3'd3: return op_sltu;
            3'd4: return op_xor;
            3'd5: if (alt) return op_sra; else return op_srl;
            3'd6: return op_or;
            default: return op_and;
        endcase
    endfunction

    task automatic report_mismatch(input string what, input string got, input string exp);
        errors++;
        $display("** Error at time %0t: %s was %s, expected %s", $time, what, got, exp);
    endtask

    task automatic check_word(input logic [xlen-1:0] got, input logic [xlen-1:0] exp,
                              input string what);
        if (got !== exp) report_mismatch(what, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_addr(input logic [reg_addr_w-1:0] got,
                              input logic [reg_addr_w-1:0] exp, input string what);
        if (got !== exp) report_mismatch(what, $sformatf("x%0d", got), $sformatf("x%0d", exp));
    endtask

    task automatic check_op(input alu_op_e got, input alu_op_e exp, input string what);
        if (got !== exp) report_mismatch(what, got.name(), exp.name());
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) report_mismatch(what, $sformatf("%b", got), $sformatf("%b", exp));
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) report_mismatch(what, $sformatf("%0d", got), $sformatf("%0d", exp));
    endtask

    // Drive for the coming edge, then judge the write-back that this edge takes
    task automatic cycle(input logic valid, input logic [xlen-1:0] word, input logic fl,
                         output logic acc);
        inst       = word;
        inst_pc    = pc_q;
        inst_valid = valid;
        flush      = fl;
        hold       = hold_q;
        #1;
        acc = valid && !id_stall;
        if (op_pending) begin
            check_op(dut.ex_aluop, exp_op, "decoded opcode");
            op_pending = 1'b0;
        end
        if (wb_we && !hold_q) begin
            if (q_addr.size() == 0) begin
                errors++;
                $display("Unexpected write-back to x%0d at time %0t", wb_addr, $time);
            end else begin
                check_addr(wb_addr, q_addr.pop_front(), "write-back register");
                check_word(wb_data, q_data.pop_front(), "write-back data");
                check_count(edge_no + 1 - q_edge.pop_front(),
                            2 + hold_edges - q_hold.pop_front(), "write-back latency");
                results++;
            end
        end
        @(negedge clk);
        edge_no++;
        if (hold_q) hold_edges++;
    endtask

    task automatic idle(input int n);
        logic acc;
        repeat (n) cycle(1'b0, 32'h0, 1'b0, acc);
    endtask

    // Present one instruction until decode takes it, then update the model in program order
    task automatic issue(input logic [xlen-1:0] word, input logic [reg_addr_w-1:0] rd,
                         input logic [xlen-1:0] value, input alu_op_e op, input logic fl,
                         output int stalls);
        logic acc;
        stalls = 0;
        acc    = 1'b0;
        while (!acc) begin
            cycle(1'b1, word, fl, acc);
            if (!acc) stalls++;
        end
        pc_q = pc_q + 32'd4;
        if (!fl) begin
            op_pending = 1'b1;
            exp_op     = op;
            if (op != op_nop && rd != 5'd0) begin
                model[rd] = value;
                q_addr.push_back(rd);
                q_data.push_back(value);
                q_edge.push_back(edge_no);
                q_hold.push_back(hold_edges);
            end
        end
    endtask

    task automatic do_r(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [4:0] rs2, output int stalls);
        logic [xlen-1:0] word;
        word = {alt ? f7_alt : 7'b0, rs2, rs1, f3, rd, opc_op};
        issue(word, rd, alu_ref(f3, alt, model[rs1], model[rs2]), op_of(f3, alt), 1'b0, stalls);
    endtask

    task automatic do_i(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [11:0] imm, output int stalls);
        logic [11:0]     field;
        logic [xlen-1:0] word;
        // Shifts carry funct7 in the upper immediate bits
        field = (f3 == 3'd1 || f3 == 3'd5) ? {alt ? f7_alt : 7'b0, imm[4:0]} : imm;
        word  = {field, rs1, f3, rd, opc_op_imm};
        issue(word, rd, alu_ref(f3, alt, model[rs1], {{20{field[11]}}, field}),
              op_of(f3, alt), 1'b0, stalls);
    endtask

    task automatic do_lui(input logic [4:0] rd, input logic [19:0] imm, output int stalls);
        issue({imm, rd, 7'b0110111}, rd, {imm, 12'b0}, op_add, 1'b0, stalls);
    endtask

    task automatic do_jal(input logic [4:0] rd, input logic [20:0] off, output int stalls);
        issue({off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111}, rd, pc_q + 32'd4,
              op_add, 1'b0, stalls);
    endtask

    task automatic check_free_then_idle(input int stalls);
        check_count(stalls, 0, "stall cycles of an independent instruction");
        idle(1);
    endtask

    task automatic test_reset();
        int st;
        check_flag(wb_we, 1'b0, "wb_we after reset");
        check_flag(id_stall, 1'b0, "id_stall after reset");
        check_flag(dut.ex_wreg, 1'b0, "ID/EX write enable after reset");
        // Unknown opcode, then an R-type word with a funct7 outside RV32I
        issue(32'hffff_ffff, 5'd31, 32'h0, op_nop, 1'b0, st);
        issue({7'b0000001, 5'd2, 5'd1, 3'd0, 5'd31, opc_op}, 5'd31, 32'h0, op_nop, 1'b0, st);
        idle(3);
    endtask

    task automatic test_arith();
        int          st;
        logic [31:0] v;
        for (int r = 1; r <= 7; r++) begin
            v = rand_next();
            do_lui(5'(r), v[31:12], st);
            check_free_then_idle(st);
            do_i(3'd0, 1'b0, 5'(r), 5'(r), v[11:0], st);
            check_free_then_idle(st);
        end
        for (int k = 0; k < 10; k++) begin
            v = rand_next();
            do_r((k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5), k >= 8, 5'(8 + v[2:0]),
                 5'(1 + v[7:4] % 15), 5'(1 + v[11:8] % 15), st);
            check_free_then_idle(st);
        end
        for (int k = 0; k < 9; k++) begin
            v = rand_next();
            do_i((k < 8) ? 3'(k) : 3'd5, k == 8, 5'(8 + v[2:0]), 5'(1 + v[7:4] % 15),
                 v[31:20], st);
            check_free_then_idle(st);
        end
    endtask

    task automatic test_link();
        int          st;
        logic [31:0] v;
        v = rand_next();
        do_jal(5'(16 + v[1:0]), v[20:0], st);
        check_free_then_idle(st);
        do_jal(5'd0, v[31:11], st);
        check_free_then_idle(st);
        do_r(3'd0, 1'b0, 5'd0, 5'd1, 5'd2, st);
        check_free_then_idle(st);
        do_i(3'd4, 1'b0, 5'd0, 5'd3, v[11:0], st);
        check_free_then_idle(st);
    endtask

    task automatic test_hazard();
        int          st;
        logic [31:0] v;
        v = rand_next();
        do_r(3'd0, 1'b0, 5'd20, 5'd1, 5'd2, st);
        do_r(3'd0, 1'b1, 5'd21, 5'd20, 5'd3, st);
        check_count(st, 1, "stall cycles of a dependent instruction");
        do_i(3'd4, 1'b0, 5'd22, 5'd21, v[11:0], st);
        check_count(st, 1, "stall cycles of a dependent instruction");
        do_r(3'd7, 1'b0, 5'd0, 5'd22, 5'd4, st);
        check_count(st, 1, "stall cycles of a dependent instruction");
        do_r(3'd6, 1'b0, 5'd23, 5'd0, 5'd0, st);
        check_count(st, 0, "stall cycles of an x0 read");
        do_i(3'd0, 1'b0, 5'd24, 5'd0, v[23:12], st);
        check_count(st, 0, "stall cycles of an x0 read");
        idle(2);
    endtask

    task automatic test_hold();
        int st;
        int n;
        n = 1 + rand_next() % 6;
        do_r(3'd4, 1'b0, 5'd25, 5'd1, 5'd2, st);
        do_r(3'd6, 1'b0, 5'd26, 5'd3, 5'd4, st);
        check_count(st, 0, "stall cycles of an independent instruction");
        hold_q = 1'b1;
        repeat (n) begin
            idle(1);
            check_flag(id_stall, 1'b1, "id_stall under hold");
        end
        hold_q = 1'b0;
        do_r(3'd0, 1'b0, 5'd27, 5'd25, 5'd1, st);
        check_count(st, 0, "stall cycles after hold");
        idle(2);
    endtask

    task automatic test_flush();
        int st;
        do_r(3'd0, 1'b0, 5'd28, 5'd1, 5'd2, st);
        // Flushed in decode, so x29 keeps its old value
        issue({7'b0, 5'd3, 5'd4, 3'd0, 5'd29, opc_op}, 5'd29, 32'h0, op_add, 1'b1, st);
        idle(2);
        do_r(3'd0, 1'b0, 5'd30, 5'd29, 5'd28, st);
        check_free_then_idle(st);
    endtask

    initial begin
        rst_n      = 1'b0;
        inst       = '0;
        inst_pc    = '0;
        inst_valid = 1'b0;
        hold       = 1'b0;
        flush      = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset();
        test_arith();
        test_link();
        test_hazard();
        test_hold();
        test_flush();
        idle(4);
        if (q_addr.size() != 0) begin
            errors++;
            $display("%0d expected write-backs never appeared", q_addr.size());
        end
        $display("Write-backs checked: %0d, errors: %0d", results, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== all.f ====
design/cpu_pkg.sv
design/inst_decode.sv
design/reg_file.sv
design/stall_ctrl.sv
design/id_ex.sv
design/alu_execute.sv
design/decode_exec_top.sv
verification/tb_top.sv

// ==== Makefile ====
TOP = tb_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing -f all.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
